/* Bender.yml */
package:
  name: ramio

export_include_dirs:
  - common

sources:
  - files:
      - common/ramio_pkg.sv
      - common/uart_pkg.sv
      - uart/uart_tx.sv
      - uart/uart_rx.sv
      - verilog/word_ram.sv
      - verilog/ramio_core.sv
      - verilog/ramio.sv
  - target: test
    files:
      - testbench/ramio_assertions.sv
      - testbench/ramio_tb.sv

/* common/ramio_defs.svh */
// ramio shared constants
// I/O register map, on-chip memory depth and UART bit timing

`ifndef RAMIO_DEFS_SVH
`define RAMIO_DEFS_SVH

// memory mapped I/O registers, top of the address space
// 4 LEDs in the low nibble, active low
`define RAMIO_ADDR_LED 32'hffff_fffc
// write starts transmission, reads all ones when idle
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8
// last received byte, cleared to all ones by a read
`define RAMIO_ADDR_UART_IN 32'hffff_fff4

// on-chip word memory
`define RAMIO_RAM_WORDS 256
`define RAMIO_RAM_AW $clog2(`RAMIO_RAM_WORDS)

// clocks per UART bit, short so simulation stays quick
// for hardware this becomes clock frequency / baud rate
`define RAMIO_CLKS_PER_BIT 8

// value an idle UART register reads back as
`define RAMIO_IDLE_WORD 32'hffff_ffff

`endif

/* common/ramio_pkg.sv */
// ramio access types
// client read and write encodings and the memory request bundle

`include "ramio_defs.svh"

package ramio_pkg;

  // bit 2 flags sign extension, bits 1:0 give the width
  typedef enum logic [2:0] {
    RD_NONE = 3'b000,
    RD_BU   = 3'b001,
    RD_HU   = 3'b010,
    RD_WORD = 3'b011,
    RD_B    = 3'b101,
    RD_H    = 3'b110
  } read_type_e;

  typedef enum logic [1:0] {
    WR_NONE = 2'b00,
    WR_B    = 2'b01,
    WR_H    = 2'b10,
    WR_W    = 2'b11
  } write_type_e;

  // one access toward word_ram
  // byte_en all zero means a read
  typedef struct packed {
    logic [`RAMIO_RAM_AW-1:0] word_addr;
    logic [31:0]              wdata;
    logic [3:0]               byte_en;
    logic                     en;
  } ram_req_t;

endpackage

/* common/uart_pkg.sv */
// UART state encodings
// shared by the 8N1 transmitter and receiver

package uart_pkg;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  // RX_HOLD keeps data_ready up until the consumer drops go
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_HOLD
  } rx_state_e;

endpackage

/* testbench/ramio_assertions.sv */
// ramio protocol checks
// bound into the top level to watch busy, LED writes and the idle line

`include "ramio_defs.svh"

module ramio_assertions (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   enable,
  input logic [31:0]            address,
  input ramio_pkg::write_type_e write_type,
  input logic                   busy,
  input logic [3:0]             led,
  input logic                   uart_tx
);
  timeunit 1ns;
  timeprecision 100ps;

  logic        io_addr;
  logic        led_wr;
  // number of failed assertions so far
  int unsigned fail_count = 0;

  assign io_addr = (address == `RAMIO_ADDR_LED) || (address == `RAMIO_ADDR_UART_OUT) ||
                   (address == `RAMIO_ADDR_UART_IN);
  assign led_wr  = enable && (address == `RAMIO_ADDR_LED) && (write_type != ramio_pkg::WR_NONE);

  // I/O registers answer at once
  io_never_busy: assert property (@(posedge clk) disable iff (!rst_n) io_addr |-> !busy)
    else begin
      fail_count++;
      $error("busy raised on an I/O address");
    end

  // led moves only on the edge that took an LED write
  led_write_only: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(led) |-> $past(led_wr))
    else begin
      fail_count++;
      $error("led changed without a write to the LED address");
    end

  // line idles high once reset has been seen
  tx_idle_in_reset: assert property (@(posedge clk) !rst_n |=> (uart_tx || rst_n))
    else begin
      fail_count++;
      $error("uart_tx low during reset");
    end

endmodule

bind ramio ramio_assertions u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .enable     (enable),
  .address    (address),
  .write_type (write_type),
  .busy       (busy),
  .led        (led),
  .uart_tx    (uart_tx)
);

/* testbench/ramio_tb.sv */
// ramio testbench
// table driven accesses over RAM, LEDs and a looped back UART
// expected RAM data comes from a reference memory kept next to the table

`include "ramio_defs.svh"

module ramio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_WAIT
  } op_e;

  // led_after is the LED state once the row is done
  typedef struct {
    string                  name;
    op_e                    op;
    logic [31:0]            addr;
    ramio_pkg::read_type_e  rt;
    ramio_pkg::write_type_e wt;
    logic [31:0]            data;
    logic [31:0]            exp;
    logic [3:0]             led_after;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   enable;
  ramio_pkg::read_type_e  read_type;
  ramio_pkg::write_type_e write_type;
  logic [31:0]            address;
  logic [31:0]            data_in;
  logic [31:0]            data_out;
  logic                   data_out_ready;
  logic                   busy;
  logic [3:0]             led;
  logic                   line_tx;
  logic                   line_rx;

  row_t        rows[$];
  logic [31:0] ref_mem [`RAMIO_RAM_WORDS];
  logic [3:0]  led_model;
  logic [31:0] rng;
  logic        table_built;

  ramio u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .uart_rx        (line_rx),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .led            (led),
    .uart_tx        (line_tx)
  );

  // serial loopback where an undriven line reads as idle
  assign line_rx = (line_tx === 1'b0) ? 1'b0 : 1'b1;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic is_io(input logic [31:0] addr);
    return addr == `RAMIO_ADDR_LED || addr == `RAMIO_ADDR_UART_OUT ||
           addr == `RAMIO_ADDR_UART_IN;
  endfunction

  // misaligned halves and words leave the word alone
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] addr,
                                              input ramio_pkg::write_type_e wt,
                                              input logic [31:0] data);
    logic [31:0] w;
    w = old;
    if (wt == ramio_pkg::WR_B) begin
      w[8*addr[1:0] +: 8] = data[7:0];
    end else if (wt == ramio_pkg::WR_H && !addr[0]) begin
      w[16*addr[1] +: 16] = data[15:0];
    end else if (wt == ramio_pkg::WR_W && addr[1:0] == 2'b00) begin
      w = data;
    end
    return w;
  endfunction

  // addressed lane extended as the read type says and zero when misaligned
  function automatic logic [31:0] extract_lane(input logic [31:0] w, input logic [31:0] addr,
                                               input ramio_pkg::read_type_e rt);
    logic [7:0]  b;
    logic [15:0] h;
    b = w >> (8 * addr[1:0]);
    h = w >> (16 * addr[1]);
    case (rt)
      ramio_pkg::RD_BU:   return {24'h0, b};
      ramio_pkg::RD_B:    return 32'($signed(b));
      ramio_pkg::RD_HU:   return addr[0] ? 32'h0 : {16'h0, h};
      ramio_pkg::RD_H:    return addr[0] ? 32'h0 : 32'($signed(h));
      ramio_pkg::RD_WORD: return (addr[1:0] != 2'b00) ? 32'h0 : w;
      default:            return 32'h0;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic add_check(input string name, input op_e op, input logic [31:0] addr,
                           input ramio_pkg::read_type_e rt, input logic [31:0] exp);
    row_t r;
    r = '{name, op, addr, rt, ramio_pkg::WR_NONE, 32'h0, exp, led_model};
    rows.push_back(r);
  endtask

  task automatic add_write(input string name, input logic [31:0] addr,
                           input ramio_pkg::write_type_e wt, input logic [31:0] data);
    row_t r;
    if (addr == `RAMIO_ADDR_LED) begin
      led_model = data[3:0];
    end else if (!is_io(addr)) begin
      ref_mem[addr[`RAMIO_RAM_AW+1:2]] = merge_lanes(ref_mem[addr[`RAMIO_RAM_AW+1:2]], addr,
                                                     wt, data);
    end
    r = '{name, OP_WRITE, addr, ramio_pkg::RD_NONE, wt, data, 32'h0, led_model};
    rows.push_back(r);
  endtask

  task automatic add_ram_read(input string name, input logic [31:0] addr,
                              input ramio_pkg::read_type_e rt);
    add_check(name, OP_READ, addr, rt, extract_lane(ref_mem[addr[`RAMIO_RAM_AW+1:2]], addr, rt));
  endtask

  task automatic build_table();
    logic [31:0] a [4];
    logic [31:0] d;
    led_model = 4'hf;
    rng = 32'he381;
    // LEDs are active low and dark out of reset
    add_check("led_reset", OP_READ, `RAMIO_ADDR_LED, ramio_pkg::RD_WORD, 32'h0000_000f);
    rng = xorshift32(rng);
    d = rng;
    add_write("led_write", `RAMIO_ADDR_LED, ramio_pkg::WR_W, d);
    add_check("led_readback", OP_READ, `RAMIO_ADDR_LED, ramio_pkg::RD_WORD, {28'h0, d[3:0]});
    // random word round trip where addresses may repeat
    for (int i = 0; i < 4; i++) begin
      rng = xorshift32(rng);
      a[i] = {22'h0, rng[9:2], 2'b00};
      rng = xorshift32(rng);
      add_write($sformatf("word_write_%0d", i), a[i], ramio_pkg::WR_W, rng);
    end
    for (int i = 0; i < 4; i++) begin
      add_ram_read($sformatf("word_read_%0d", i), a[i], ramio_pkg::RD_WORD);
    end
    // sub-word merge into a known word
    add_write("merge_base", 32'h40, ramio_pkg::WR_W, 32'h1122_3344);
    add_write("merge_byte", 32'h41, ramio_pkg::WR_B, 32'h0000_00aa);
    add_write("merge_half", 32'h42, ramio_pkg::WR_H, 32'h0000_beef);
    add_write("merge_misaligned", 32'h41, ramio_pkg::WR_H, 32'h0000_dead);
    add_ram_read("merge_word", 32'h40, ramio_pkg::RD_WORD);
    // extension with both signs in every lane width
    add_write("ext_base", 32'h80, ramio_pkg::WR_W, 32'h80f1_7f85);
    add_ram_read("ext_b_neg", 32'h80, ramio_pkg::RD_B);
    add_ram_read("ext_bu", 32'h80, ramio_pkg::RD_BU);
    add_ram_read("ext_b_pos", 32'h81, ramio_pkg::RD_B);
    add_ram_read("ext_h_neg", 32'h82, ramio_pkg::RD_H);
    add_ram_read("ext_hu", 32'h82, ramio_pkg::RD_HU);
    add_ram_read("ext_h_pos", 32'h80, ramio_pkg::RD_H);
    add_ram_read("ext_h_misaligned", 32'h81, ramio_pkg::RD_H);
    // UART out and the same byte back through the loopback
    rng = xorshift32(rng);
    d = rng;
    add_write("uart_out_write", `RAMIO_ADDR_UART_OUT, ramio_pkg::WR_W, d);
    add_check("uart_out_pending", OP_READ, `RAMIO_ADDR_UART_OUT, ramio_pkg::RD_WORD,
              {24'h0, d[7:0]});
    add_check("uart_out_wait", OP_WAIT, `RAMIO_ADDR_UART_OUT, ramio_pkg::RD_WORD,
              `RAMIO_IDLE_WORD);
    add_check("uart_out_idle", OP_READ, `RAMIO_ADDR_UART_OUT, ramio_pkg::RD_WORD,
              `RAMIO_IDLE_WORD);
    add_check("uart_in_byte", OP_READ, `RAMIO_ADDR_UART_IN, ramio_pkg::RD_WORD, {24'h0, d[7:0]});
    add_check("uart_in_cleared", OP_READ, `RAMIO_ADDR_UART_IN, ramio_pkg::RD_WORD,
              `RAMIO_IDLE_WORD);
    add_check("led_final", OP_READ, `RAMIO_ADDR_LED, ramio_pkg::RD_WORD, {28'h0, led_model});
  endtask

  task automatic apply_row(input row_t r);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    enable     <= 1'b1;
    address    <= r.addr;
    read_type  <= r.rt;
    write_type <= r.wt;
    data_in    <= r.data;
    if (r.op == OP_WRITE) begin
      // write lands on the next edge
      @(posedge clk);
    end else begin
      @(negedge clk);
      // a wait row keeps reading until the register shows the expected value
      // and that has to happen within one UART frame
      while (!data_out_ready || (r.op == OP_WAIT && data_out !== r.exp)) begin
        assert (data_out_ready || busy) else begin
          abort_run($sformatf("%s stalled with busy low and no data ready", r.name));
        end
        assert (waited < 10 * `RAMIO_CLKS_PER_BIT + 1) else begin
          abort_run($sformatf("%s still not done after %0d cycles", r.name, waited));
        end
        waited++;
        @(negedge clk);
      end
      // I/O reads answer in the enable cycle and RAM reads one cycle later
      if (r.op == OP_READ) begin
        assert (waited == (is_io(r.addr) ? 0 : 1)) else begin
          abort_run($sformatf("ERR %s latency expected %0d actual %0d", r.name,
                              is_io(r.addr) ? 0 : 1, waited));
        end
      end
      assert (data_out === r.exp) else begin
        abort_run($sformatf("ERR %s expected %h actual %h", r.name, r.exp, data_out));
      end
      assert (busy === 1'b0) else begin
        abort_run($sformatf("ERR %s busy expected 0 actual %b", r.name, busy));
      end
      @(posedge clk);
    end
    enable     <= 1'b0;
    read_type  <= ramio_pkg::RD_NONE;
    write_type <= ramio_pkg::WR_NONE;
    @(negedge clk);
    assert (led === r.led_after) else begin
      abort_run($sformatf("ERR %s led expected %b actual %b", r.name, r.led_after, led));
    end
  endtask

  // budget per row covers one full UART frame with margin
  initial begin : watchdog
    int unsigned limit;
    wait (table_built === 1'b1);
    limit = rows.size() * (12 * `RAMIO_CLKS_PER_BIT + 8);
    repeat (limit) @(posedge clk);
    abort_run($sformatf("timeout after %0d cycles, the run hung", limit));
  end

  // a failed bound assertion ends the run at once
  initial begin : assertion_monitor
    wait (u_dut.u_assertions.fail_count != 0);
    abort_run("a protocol assertion on the DUT ports failed");
  end

  initial begin
    rst_n       = 1'b0;
    enable      = 1'b0;
    read_type   = ramio_pkg::RD_NONE;
    write_type  = ramio_pkg::WR_NONE;
    address     = 32'h0;
    data_in     = 32'h0;
    table_built = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* uart/uart_rx.sv */
// UART receiver, 8N1
// start edge detect, mid-bit sampling, data held until go drops

`include "ramio_defs.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT);

  uart_pkg::rx_state_e state;
  logic [CNT_W-1:0]    cnt;
  logic [2:0]          bit_idx;
  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic                half_done;
  logic                bit_done;

  assign half_done = (cnt == CNT_W'(`RAMIO_CLKS_PER_BIT / 2 - 1));
  assign bit_done  = (cnt == CNT_W'(`RAMIO_CLKS_PER_BIT - 1));

  // two flop synchroniser, line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= uart_pkg::RX_IDLE;
      cnt        <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      cnt <= bit_done ? '0 : cnt + 1'b1;
      case (state)
        uart_pkg::RX_IDLE: begin
          cnt <= '0;
          // falling edge starts a frame, only when the consumer is ready
          if (go && rx_prev && !rx_sync) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          // middle of start bit, still low or it was a glitch
          if (half_done) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          // one full period lands in the middle of the next bit
          if (bit_done) begin
            data    <= {rx_sync, data[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::RX_STOP;
            end
          end
        end
        uart_pkg::RX_STOP: begin
          // middle of stop bit, byte complete
          if (bit_done) begin
            data_ready <= 1'b1;
            state      <= uart_pkg::RX_HOLD;
          end
        end
        default: begin
          cnt <= '0;
          if (!go) begin
            data_ready <= 1'b0;
            state      <= uart_pkg::RX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* uart/uart_tx.sv */
// UART transmitter, 8N1
// latches data on go, sends start bit, 8 data bits lsb first, stop bit

`include "ramio_defs.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       tx,
  output logic       busy
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT);

  uart_pkg::tx_state_e state;
  logic [CNT_W-1:0]    cnt;
  logic [2:0]          bit_idx;
  logic [7:0]          shreg;
  logic                bit_done;

  // last clock of the current bit period
  assign bit_done = (cnt == CNT_W'(`RAMIO_CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= uart_pkg::TX_IDLE;
      tx      <= 1'b1;
      busy    <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= bit_done ? '0 : cnt + 1'b1;
      case (state)
        uart_pkg::TX_IDLE: begin
          cnt <= '0;
          // go is ignored while a frame is on the line
          if (go) begin
            shreg <= data;
            tx    <= 1'b0;
            busy  <= 1'b1;
            state <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_done) begin
            tx      <= shreg[0];
            shreg   <= shreg >> 1;
            bit_idx <= '0;
            state   <= uart_pkg::TX_DATA;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              // stop bit
              tx    <= 1'b1;
              state <= uart_pkg::TX_STOP;
            end else begin
              tx    <= shreg[0];
              shreg <= shreg >> 1;
            end
          end
        end
        default: begin
          // stop bit ends, line stays high
          if (bit_done) begin
            busy  <= 1'b0;
            state <= uart_pkg::TX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* verilog.f */
+incdir+common
common/ramio_pkg.sv
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/word_ram.sv
verilog/ramio_core.sv
verilog/ramio.sv
testbench/ramio_assertions.sv
testbench/ramio_tb.sv

/* verilog/ramio.sv */
// ramio top level
// memory mapped RAM, LEDs and UART for a small processor core

module ramio (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable,
  input  ramio_pkg::read_type_e  read_type,
  input  ramio_pkg::write_type_e write_type,
  input  logic [31:0]            address,
  input  logic [31:0]            data_in,
  input  logic                   uart_rx,
  output logic [31:0]            data_out,
  output logic                   data_out_ready,
  output logic                   busy,
  output logic [3:0]             led,
  output logic                   uart_tx
);

  ramio_pkg::ram_req_t ram_req;
  logic [31:0]         ram_rdata;
  logic                ram_ready;
  logic [7:0]          tx_byte;
  logic                tx_go;
  logic                tx_busy;
  logic [7:0]          rx_byte;
  logic                rx_data_ready;
  logic                rx_go;

  ramio_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .ram_rdata      (ram_rdata),
    .ram_ready      (ram_ready),
    .tx_busy        (tx_busy),
    .rx_byte        (rx_byte),
    .rx_data_ready  (rx_data_ready),
    .ram_req        (ram_req),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .led            (led),
    .tx_byte        (tx_byte),
    .tx_go          (tx_go),
    .rx_go          (rx_go)
  );

  word_ram u_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (ram_req),
    .rdata (ram_rdata),
    .ready (ram_ready)
  );

  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .data  (tx_byte),
    .go    (tx_go),
    .tx    (uart_tx),
    .busy  (tx_busy)
  );

  uart_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_byte),
    .data_ready (rx_data_ready)
  );

endmodule

/* verilog/ramio_core.sv */
// ramio core
// decodes the I/O addresses, steers writes into byte lanes, extracts and
// extends read lanes, and holds the LED and UART registers

`include "ramio_defs.svh"

module ramio_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable,
  input  ramio_pkg::read_type_e  read_type,
  input  ramio_pkg::write_type_e write_type,
  input  logic [31:0]            address,
  input  logic [31:0]            data_in,
  input  logic [31:0]            ram_rdata,
  input  logic                   ram_ready,
  input  logic                   tx_busy,
  input  logic [7:0]             rx_byte,
  input  logic                   rx_data_ready,
  output ramio_pkg::ram_req_t    ram_req,
  output logic [31:0]            data_out,
  output logic                   data_out_ready,
  output logic                   busy,
  output logic [3:0]             led,
  output logic [7:0]             tx_byte,
  output logic                   tx_go,
  output logic                   rx_go
);

  logic        sel_led;
  logic        sel_uart_out;
  logic        sel_uart_in;
  logic        is_io;
  logic        is_rd;
  logic        is_wr;
  logic [31:0] uart_out_reg;
  logic [31:0] uart_in_reg;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;
  logic [31:0] ram_word;
  logic        sext;

  // address decode
  assign sel_led      = (address == `RAMIO_ADDR_LED);
  assign sel_uart_out = (address == `RAMIO_ADDR_UART_OUT);
  assign sel_uart_in  = (address == `RAMIO_ADDR_UART_IN);
  assign is_io        = sel_led || sel_uart_out || sel_uart_in;
  assign is_rd        = (read_type != ramio_pkg::RD_NONE);
  assign is_wr        = (write_type != ramio_pkg::WR_NONE);

  // I/O answers at once, RAM reads wait for the memory
  assign busy           = enable && !is_io && is_rd && !ram_ready;
  assign data_out_ready = enable && (is_io || ram_ready);

  // write lane steering, misaligned half words and words get no enables
  always_comb begin
    ram_req.en        = enable && !is_io;
    ram_req.word_addr = address[`RAMIO_RAM_AW+1:2];
    ram_req.byte_en   = 4'b0000;
    ram_req.wdata     = '0;
    if (enable && !is_io) begin
      case (write_type)
        ramio_pkg::WR_B: begin
          ram_req.byte_en = 4'b0001 << address[1:0];
          ram_req.wdata   = {4{data_in[7:0]}};
        end
        ramio_pkg::WR_H: begin
          if (!address[0]) begin
            ram_req.byte_en = address[1] ? 4'b1100 : 4'b0011;
          end
          ram_req.wdata = {2{data_in[15:0]}};
        end
        ramio_pkg::WR_W: begin
          if (address[1:0] == 2'b00) begin
            ram_req.byte_en = 4'b1111;
          end
          ram_req.wdata = data_in;
        end
        default: ;
      endcase
    end
  end

  // read lane extraction
  assign rd_byte = ram_rdata[8*address[1:0] +: 8];
  assign rd_half = address[1] ? ram_rdata[31:16] : ram_rdata[15:0];
  assign sext    = read_type[2];

  always_comb begin
    case (read_type[1:0])
      2'b01: ram_word = {{24{sext & rd_byte[7]}}, rd_byte};
      2'b10: ram_word = address[0] ? '0 : {{16{sext & rd_half[15]}}, rd_half};
      2'b11: ram_word = (address[1:0] != 2'b00) ? '0 : ram_rdata;
      default: ram_word = '0;
    endcase
  end

  // I/O reads bypass the memory entirely
  always_comb begin
    if (sel_uart_out) begin
      data_out = uart_out_reg;
    end else if (sel_uart_in) begin
      data_out = uart_in_reg;
    end else if (sel_led) begin
      data_out = {28'h0, led};
    end else begin
      data_out = ram_word;
    end
  end

  assign tx_byte = uart_out_reg[7:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led          <= 4'b1111;
      uart_out_reg <= `RAMIO_IDLE_WORD;
      tx_go        <= 1'b0;
      uart_in_reg  <= `RAMIO_IDLE_WORD;
      rx_go        <= 1'b1;
    end else begin
      // go is a single cycle pulse
      tx_go <= 1'b0;

      // UART out, a new write overwrites whatever is pending
      // tx_go high means busy is not visible yet, so it doubles as the guard
      if (enable && sel_uart_out && is_wr) begin
        uart_out_reg <= {24'h0, data_in[7:0]};
        tx_go        <= 1'b1;
      end else if (!tx_go && !tx_busy) begin
        uart_out_reg <= `RAMIO_IDLE_WORD;
      end

      // UART in, a read wins over a byte landing on the same edge
      if (enable && sel_uart_in && is_rd) begin
        uart_in_reg <= `RAMIO_IDLE_WORD;
      end else if (rx_go && rx_data_ready) begin
        uart_in_reg <= {24'h0, rx_byte};
        // drop go for one cycle so the receiver releases data_ready
        rx_go       <= 1'b0;
      end
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // LEDs
      if (enable && sel_led && is_wr) begin
        led <= data_in[3:0];
      end
    end
  end

endmodule

/* verilog/word_ram.sv */
// on-chip word memory
// byte lane writes, registered read, ready once the address has held a cycle

`include "ramio_defs.svh"

module word_ram (
  input  logic                clk,
  input  logic                rst_n,
  input  ramio_pkg::ram_req_t req,
  output logic [31:0]         rdata,
  output logic                ready
);

  logic [31:0]              mem [`RAMIO_RAM_WORDS];
  logic [`RAMIO_RAM_AW-1:0] last_addr;
  logic                     last_rd;
  logic                     is_rd;

  // a request with no byte enables is a read
  assign is_rd = req.en && (req.byte_en == 4'b0000);

  // byte lane writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (req.en && req.byte_en[i]) begin
        mem[req.word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
      end
    end
  end

  // read word, one cycle latency
  always_ff @(posedge clk) begin
    if (req.en) begin
      rdata <= mem[req.word_addr];
    end
  end

  // remember what was read last cycle
  // writes clear it so a stale word is never flagged
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_rd   <= 1'b0;
      last_addr <= '0;
    end else begin
      last_rd   <= is_rd;
      last_addr <= req.word_addr;
    end
  end

  assign ready = is_rd && last_rd && (last_addr == req.word_addr);

endmodule
